// File: Bender.yml
package:
  name: qdrc

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/qdrc_pkg.sv
      - src/qdrc_phy_sm.sv
      - src/qdrc_phy_bit_align.sv
      - src/qdrc_phy_burst_align.sv
      - src/qdrc_phy.sv
      - src/qdrc_ctrl.sv
      - src/qdrc_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/qdr_sram_model.sv
      - verification/tb_qdrc_top.sv

// File: all.f
+incdir+src
src/qdrc_pkg.sv
src/qdrc_phy_sm.sv
src/qdrc_phy_bit_align.sv
src/qdrc_phy_burst_align.sv
src/qdrc_phy.sv
src/qdrc_ctrl.sv
src/qdrc_top.sv
verification/qdr_sram_model.sv
verification/tb_qdrc_top.sv

// File: src/qdrc_config.svh
`ifndef QDRC_CONFIG_SVH
`define QDRC_CONFIG_SVH

// ******************************
// sram geometry
// ******************************
`define QDR_DATA_WIDTH 18 // one data half.
`define QDR_BW_WIDTH   2  // byte writes per half.
`define QDR_ADDR_WIDTH 8  // small array for simulation.

// ******************************
// calibration limits
// ******************************
`define QDR_MAX_SKEW 4  // tap positions per bit.
`define QDR_MAX_LAT  12 // longest read latency accepted.

// probe locations, top of the array.
`define QDR_CAL_ADDR0 8'hFE
`define QDR_CAL_ADDR1 8'hFF

`endif

// File: src/qdrc_ctrl.sv
`timescale 1ns/10ps

module qdrc_ctrl import qdrc_pkg::*; (
  input  logic      clk0,
  input  logic      arst_n,
  input  logic      req,
  input  user_req_t user_req,
  output logic      ack,
  output qdr_word_t rd_data,
  input  logic      phy_rdy,
  input  lat_t      phy_rd_lat,
  input  qdr_word_t phy_rd_data,
  output logic      phy_wr_strb,
  output logic      phy_rd_strb,
  output qdr_addr_t phy_addr,
  output qdr_word_t phy_wr_data,
  output qdr_ben_t  phy_wr_ben
);

  typedef enum logic [1:0] {C_IDLE, C_ISSUE, C_WAIT, C_ACK} ctrl_state_e;

  ctrl_state_e state;
  lat_t        cnt;
  logic        accept;
  logic        capture;

  assign accept  = (state == C_IDLE) && req && phy_rdy;
  assign capture = (state == C_WAIT) && (cnt == phy_rd_lat);

  // ******************************
  // request handshake
  // ******************************
  always_ff @(posedge clk0 or negedge arst_n) begin
    if (!arst_n) begin
      state       <= C_IDLE;
      cnt         <= '0;
      ack         <= 1'b0;
      phy_wr_strb <= 1'b0;
      phy_rd_strb <= 1'b0;
    end else begin
      case (state)
        C_IDLE: begin
          if (accept) begin
            phy_wr_strb <= user_req.we;
            phy_rd_strb <= !user_req.we;
            state       <= C_ISSUE;
          end
        end
        C_ISSUE: begin // strobe cycle.
          phy_wr_strb <= 1'b0;
          phy_rd_strb <= 1'b0;
          if (phy_wr_strb) begin
            ack   <= 1'b1;
            state <= C_ACK;
          end else begin
            cnt   <= lat_t'(1);
            state <= C_WAIT;
          end
        end
        C_WAIT: begin
          if (capture) begin
            ack   <= 1'b1;
            state <= C_ACK;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        C_ACK: begin
          if (!req) begin
            ack   <= 1'b0;
            state <= C_IDLE;
          end
        end
        default: state <= C_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk0) begin
    if (accept) begin
      phy_addr    <= user_req.addr;
      phy_wr_data <= user_req.wdata;
      phy_wr_ben  <= user_req.ben;
    end
    if (capture) rd_data <= phy_rd_data; // held while ack is high.
  end

  a_ack_holds: assert property (
    @(posedge clk0) disable iff (!arst_n) (ack && req) |=> ack
  );

endmodule

// File: src/qdrc_phy.sv
`timescale 1ns/10ps
`include "qdrc_config.svh"

module qdrc_phy import qdrc_pkg::*; (
  input  logic          clk0,
  input  logic          arst_n,
  input  logic          phy_wr_strb,
  input  logic          phy_rd_strb,
  input  qdr_addr_t     phy_addr,
  input  qdr_word_t     phy_wr_data,
  input  qdr_ben_t      phy_wr_ben,
  output qdr_word_t     phy_rd_data,
  output lat_t          phy_rd_lat,
  output logic          phy_rdy,
  output logic          cal_fail,
  output logic          qdr_dll_off_n,
  output qdr_pins_out_t qdr_out,
  input  qdr_pins_in_t  qdr_in
);

  logic          bit_align_start, bit_align_done, bit_align_fail;
  logic          burst_align_start, burst_align_done, burst_align_fail;
  qdr_pins_out_t pins_bit;
  qdr_pins_out_t pins_burst;
  qdr_pins_out_t pins_user;
  qdr_pins_in_t  q_cal;
  qdr_pins_in_t  q_done;

  qdrc_phy_sm u_phy_sm (
    .clk0              (clk0),
    .arst_n            (arst_n),
    .qdr_dll_off_n     (qdr_dll_off_n),
    .phy_rdy           (phy_rdy),
    .cal_fail          (cal_fail),
    .bit_align_start   (bit_align_start),
    .bit_align_done    (bit_align_done),
    .bit_align_fail    (bit_align_fail),
    .burst_align_start (burst_align_start),
    .burst_align_done  (burst_align_done),
    .burst_align_fail  (burst_align_fail)
  );

  qdrc_phy_bit_align u_bit_align (
    .clk0            (clk0),
    .arst_n          (arst_n),
    .bit_align_start (bit_align_start),
    .bit_align_done  (bit_align_done),
    .bit_align_fail  (bit_align_fail),
    .qdr_out         (pins_bit),
    .qdr_in          (qdr_in),
    .q_cal           (q_cal)
  );

  qdrc_phy_burst_align u_burst_align (
    .clk0              (clk0),
    .arst_n            (arst_n),
    .burst_align_start (burst_align_start),
    .burst_align_done  (burst_align_done),
    .burst_align_fail  (burst_align_fail),
    .qdr_out           (pins_burst),
    .q_cal             (q_cal),
    .q_done            (q_done),
    .rd_lat            (phy_rd_lat)
  );

  // ******************************
  // pin multiplexer
  // ******************************
  assign pins_user.d_rise    = phy_wr_data[`QDR_DATA_WIDTH-1:0];
  assign pins_user.d_fall    = phy_wr_data[2*`QDR_DATA_WIDTH-1:`QDR_DATA_WIDTH];
  assign pins_user.bw_n_rise = ~phy_wr_ben[`QDR_BW_WIDTH-1:0]; // pins are active low.
  assign pins_user.bw_n_fall = ~phy_wr_ben[2*`QDR_BW_WIDTH-1:`QDR_BW_WIDTH];
  assign pins_user.sa        = phy_addr;
  assign pins_user.w_n       = ~phy_wr_strb;
  assign pins_user.r_n       = ~phy_rd_strb;

  assign qdr_out = !bit_align_done   ? pins_bit   :
                   !burst_align_done ? pins_burst :
                                       pins_user;

  assign phy_rd_data = {q_done.q_fall, q_done.q_rise}; // fall in upper half.

endmodule

// File: src/qdrc_phy_bit_align.sv
`timescale 1ns/10ps
`include "qdrc_config.svh"

module qdrc_phy_bit_align import qdrc_pkg::*; (
  input  logic          clk0,
  input  logic          arst_n,
  input  logic          bit_align_start,
  output logic          bit_align_done,
  output logic          bit_align_fail,
  output qdr_pins_out_t qdr_out,
  input  qdr_pins_in_t  qdr_in,
  output qdr_pins_in_t  q_cal
);

  localparam int NBITS = 2 * `QDR_DATA_WIDTH;
  localparam int LIMIT = `QDR_MAX_LAT + `QDR_MAX_SKEW;
  localparam int CNT_W = $clog2(LIMIT + 1);

  typedef logic [CNT_W-1:0] cnt_t;

  typedef enum logic [3:0] {
    BA_IDLE, BA_WR0, BA_WR1, BA_RD0, BA_RD1, BA_MEAS, BA_CHECK, BA_DONE, BA_FAIL
  } ba_state_e;

  ba_state_e        state;
  cnt_t             cnt;
  cnt_t             arr [NBITS];
  cnt_t             arr_max;
  cnt_t             arr_min;
  logic [NBITS-1:0] seen;
  tap_t             taps [NBITS];
  logic [NBITS-1:0] q_raw;
  logic [NBITS-1:0] q_algn;
  logic [NBITS-1:0] dly_q [1:`QDR_MAX_SKEW-1];

  assign q_raw = {qdr_in.q_fall, qdr_in.q_rise};

  // ******************************
  // probe pins
  // ******************************
  always_comb begin
    qdr_out           = '0;
    qdr_out.bw_n_rise = '1;
    qdr_out.bw_n_fall = '1;
    qdr_out.w_n       = 1'b1;
    qdr_out.r_n       = 1'b1;
    case (state)
      BA_WR0: begin
        qdr_out.w_n       = 1'b0; // zeros to addr0.
        qdr_out.bw_n_rise = '0;
        qdr_out.bw_n_fall = '0;
        qdr_out.sa        = `QDR_CAL_ADDR0;
      end
      BA_WR1: begin
        qdr_out.w_n       = 1'b0; // ones to addr1.
        qdr_out.bw_n_rise = '0;
        qdr_out.bw_n_fall = '0;
        qdr_out.d_rise    = '1;
        qdr_out.d_fall    = '1;
        qdr_out.sa        = `QDR_CAL_ADDR1;
      end
      BA_RD0, BA_MEAS: begin
        qdr_out.r_n = 1'b0;
        qdr_out.sa  = `QDR_CAL_ADDR0;
      end
      BA_RD1: begin
        qdr_out.r_n = 1'b0; // count starts here.
        qdr_out.sa  = `QDR_CAL_ADDR1;
      end
      default: ;
    endcase
  end

  always_comb begin
    arr_max = '0;
    arr_min = '1;
    for (int i = 0; i < NBITS; i++) begin
      if (arr[i] > arr_max) arr_max = arr[i];
      if (arr[i] < arr_min) arr_min = arr[i];
    end
  end

  // ******************************
  // measurement sequence
  // ******************************
  always_ff @(posedge clk0 or negedge arst_n) begin
    if (!arst_n) begin
      state <= BA_IDLE;
      cnt   <= '0;
      seen  <= '0;
      for (int i = 0; i < NBITS; i++) taps[i] <= '0;
    end else begin
      case (state)
        BA_IDLE: if (bit_align_start) state <= BA_WR0;
        BA_WR0:  state <= BA_WR1;
        BA_WR1:  state <= BA_RD0;
        BA_RD0:  state <= BA_RD1;
        BA_RD1: begin
          cnt   <= cnt_t'(1);
          state <= BA_MEAS;
        end
        BA_MEAS: begin
          seen <= seen | q_raw; // first rising edge per bit.
          if (&seen) state <= BA_CHECK;
          else if (cnt == cnt_t'(LIMIT)) state <= BA_FAIL;
          else cnt <= cnt + 1'b1;
        end
        BA_CHECK: begin
          if ((arr_max - arr_min) >= `QDR_MAX_SKEW) begin
            state <= BA_FAIL;
          end else begin
            for (int i = 0; i < NBITS; i++) taps[i] <= tap_t'(arr_max - arr[i]);
            state <= BA_DONE;
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk0) begin
    if (state == BA_MEAS) begin
      for (int i = 0; i < NBITS; i++) begin
        if (q_raw[i] && !seen[i]) arr[i] <= cnt;
      end
    end
  end

  assign bit_align_done = (state == BA_DONE);
  assign bit_align_fail = (state == BA_FAIL);

  // ******************************
  // tap delay lines
  // ******************************
  always_ff @(posedge clk0) begin
    dly_q[1] <= q_raw;
    for (int k = 2; k < `QDR_MAX_SKEW; k++) dly_q[k] <= dly_q[k-1];
  end

  for (genvar b = 0; b < NBITS; b++) begin : g_tap
    // tap 0 passes straight through.
    assign q_algn[b] = (taps[b] == '0) ? q_raw[b] : dly_q[taps[b]][b];

    a_tap_range: assert property (
      @(posedge clk0) disable iff (!arst_n)
      bit_align_done |-> (arr_max - arr[b]) < `QDR_MAX_SKEW
    );
  end

  assign q_cal.q_rise = q_algn[`QDR_DATA_WIDTH-1:0];
  assign q_cal.q_fall = q_algn[NBITS-1:`QDR_DATA_WIDTH];

endmodule

// File: src/qdrc_phy_burst_align.sv
`timescale 1ns/10ps
`include "qdrc_config.svh"

module qdrc_phy_burst_align import qdrc_pkg::*; (
  input  logic          clk0,
  input  logic          arst_n,
  input  logic          burst_align_start,
  output logic          burst_align_done,
  output logic          burst_align_fail,
  output qdr_pins_out_t qdr_out,
  input  qdr_pins_in_t  q_cal,
  output qdr_pins_in_t  q_done,
  output lat_t          rd_lat
);

  localparam qdr_data_t PAT = {(`QDR_DATA_WIDTH / 2){2'b10}};

  typedef enum logic [2:0] {
    BU_IDLE, BU_WR, BU_RD, BU_WAIT, BU_DONE, BU_FAIL
  } bu_state_e;

  bu_state_e state;
  lat_t      cnt;
  logic      hit_ok;
  logic      hit_swap;

  assign hit_ok   = (q_cal.q_rise == PAT) && (q_cal.q_fall == ~PAT);
  assign hit_swap = (q_cal.q_rise == ~PAT) && (q_cal.q_fall == PAT); // halves swapped.

  always_comb begin
    qdr_out           = '0;
    qdr_out.bw_n_rise = '1;
    qdr_out.bw_n_fall = '1;
    qdr_out.w_n       = 1'b1;
    qdr_out.r_n       = 1'b1;
    if (state == BU_WR) begin
      qdr_out.w_n       = 1'b0;
      qdr_out.bw_n_rise = '0;
      qdr_out.bw_n_fall = '0;
      qdr_out.d_rise    = PAT;
      qdr_out.d_fall    = ~PAT;
      qdr_out.sa        = `QDR_CAL_ADDR0;
    end else if (state == BU_RD) begin
      qdr_out.r_n = 1'b0; // latency counted from here.
      qdr_out.sa  = `QDR_CAL_ADDR0;
    end
  end

  always_ff @(posedge clk0 or negedge arst_n) begin
    if (!arst_n) begin
      state  <= BU_IDLE;
      cnt    <= '0;
      rd_lat <= '0;
    end else begin
      case (state)
        BU_IDLE: if (burst_align_start) state <= BU_WR;
        BU_WR:   state <= BU_RD;
        BU_RD: begin
          cnt   <= lat_t'(1);
          state <= BU_WAIT;
        end
        BU_WAIT: begin
          if (hit_ok) begin
            rd_lat <= cnt + 1'b1; // plus the q_done register.
            state  <= BU_DONE;
          end else if (hit_swap || cnt == lat_t'(`QDR_MAX_LAT)) begin
            state <= BU_FAIL;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk0) begin
    q_done <= q_cal;
  end

  assign burst_align_done = (state == BU_DONE);
  assign burst_align_fail = (state == BU_FAIL);

endmodule

// File: src/qdrc_phy_sm.sv
`timescale 1ns/10ps

module qdrc_phy_sm import qdrc_pkg::*; (
  input  logic clk0,
  input  logic arst_n,
  output logic qdr_dll_off_n,
  output logic phy_rdy,
  output logic cal_fail,
  output logic bit_align_start,
  input  logic bit_align_done,
  input  logic bit_align_fail,
  output logic burst_align_start,
  input  logic burst_align_done,
  input  logic burst_align_fail
);

  phy_sm_state_e state;

  always_ff @(posedge clk0 or negedge arst_n) begin
    if (!arst_n) begin
      state             <= IDLE;
      qdr_dll_off_n     <= 1'b0; // dll held off in reset.
      bit_align_start   <= 1'b0;
      burst_align_start <= 1'b0;
      phy_rdy           <= 1'b0;
      cal_fail          <= 1'b0;
    end else begin
      qdr_dll_off_n <= 1'b1;
      case (state)
        IDLE: begin
          if (qdr_dll_off_n) begin // one cycle after the dll is on.
            bit_align_start <= 1'b1;
            state           <= BIT_ALIGN;
          end
        end
        BIT_ALIGN: begin
          if (bit_align_fail) begin
            cal_fail <= 1'b1;
            state    <= FAIL;
          end else if (bit_align_done) begin
            burst_align_start <= 1'b1;
            state             <= BURST_ALIGN;
          end
        end
        BURST_ALIGN: begin
          if (burst_align_fail) begin
            cal_fail <= 1'b1;
            state    <= FAIL;
          end else if (burst_align_done) begin
            phy_rdy <= 1'b1;
            state   <= READY;
          end
        end
        default: ; // ready and fail hold until reset.
      endcase
    end
  end

  a_rdy_not_fail: assert property (
    @(posedge clk0) disable iff (!arst_n) !(phy_rdy && cal_fail)
  );

endmodule

// File: src/qdrc_pkg.sv
`include "qdrc_config.svh"

package qdrc_pkg;

  // ******************************
  // plain vectors
  // ******************************
  typedef logic [`QDR_DATA_WIDTH-1:0]   qdr_data_t; // one half.
  typedef logic [2*`QDR_DATA_WIDTH-1:0] qdr_word_t; // fall over rise.
  typedef logic [`QDR_ADDR_WIDTH-1:0]   qdr_addr_t;
  typedef logic [`QDR_BW_WIDTH-1:0]     qdr_bw_t;   // pin byte writes, active low.
  typedef logic [2*`QDR_BW_WIDTH-1:0]   qdr_ben_t;  // user byte enables, active high.
  typedef logic [1:0]                   tap_t;      // delay line select.
  typedef logic [3:0]                   lat_t;      // latency in cycles.

  // ******************************
  // bundles
  // ******************************
  typedef struct packed {
    qdr_data_t d_rise;
    qdr_data_t d_fall;
    qdr_bw_t   bw_n_rise;
    qdr_bw_t   bw_n_fall;
    qdr_addr_t sa;
    logic      w_n;
    logic      r_n;
  } qdr_pins_out_t;

  typedef struct packed {
    qdr_data_t q_rise;
    qdr_data_t q_fall;
  } qdr_pins_in_t;

  typedef struct packed {
    logic      we;
    qdr_addr_t addr;
    qdr_word_t wdata;
    qdr_ben_t  ben;
  } user_req_t;

  typedef enum logic [2:0] {
    IDLE,
    BIT_ALIGN,
    BURST_ALIGN,
    READY,
    FAIL
  } phy_sm_state_e;

endpackage

// File: src/qdrc_top.sv
`timescale 1ns/10ps

module qdrc_top import qdrc_pkg::*; (
  input  logic          clk0,
  input  logic          arst_n,
  input  logic          req,
  input  user_req_t     user_req,
  output logic          ack,
  output qdr_word_t     rd_data,
  output logic          phy_rdy,
  output logic          cal_fail,
  output qdr_pins_out_t qdr_out,
  input  qdr_pins_in_t  qdr_in
);

  logic      phy_wr_strb;
  logic      phy_rd_strb;
  qdr_addr_t phy_addr;
  qdr_word_t phy_wr_data;
  qdr_ben_t  phy_wr_ben;
  qdr_word_t phy_rd_data;
  lat_t      phy_rd_lat;

  qdrc_ctrl u_ctrl (
    .clk0        (clk0),
    .arst_n      (arst_n),
    .req         (req),
    .user_req    (user_req),
    .ack         (ack),
    .rd_data     (rd_data),
    .phy_rdy     (phy_rdy),
    .phy_rd_lat  (phy_rd_lat),
    .phy_rd_data (phy_rd_data),
    .phy_wr_strb (phy_wr_strb),
    .phy_rd_strb (phy_rd_strb),
    .phy_addr    (phy_addr),
    .phy_wr_data (phy_wr_data),
    .phy_wr_ben  (phy_wr_ben)
  );

  qdrc_phy u_phy (
    .clk0          (clk0),
    .arst_n        (arst_n),
    .phy_wr_strb   (phy_wr_strb),
    .phy_rd_strb   (phy_rd_strb),
    .phy_addr      (phy_addr),
    .phy_wr_data   (phy_wr_data),
    .phy_wr_ben    (phy_wr_ben),
    .phy_rd_data   (phy_rd_data),
    .phy_rd_lat    (phy_rd_lat),
    .phy_rdy       (phy_rdy),
    .cal_fail      (cal_fail),
    .qdr_dll_off_n (), // sram model has no dll pin.
    .qdr_out       (qdr_out),
    .qdr_in        (qdr_in)
  );

endmodule

// File: verification/qdr_sram_model.sv
`timescale 1ns/10ps
`include "qdrc_config.svh"

module qdr_sram_model import qdrc_pkg::*; (
  input  logic                                clk0,
  input  lat_t                                base_lat,
  input  logic [2*`QDR_DATA_WIDTH-1:0][1:0]   skew,
  input  qdr_pins_out_t                       qdr_out,
  output qdr_pins_in_t                        qdr_in
);

  localparam int NBITS  = 2 * `QDR_DATA_WIDTH;
  localparam int BYTE_W = `QDR_DATA_WIDTH / `QDR_BW_WIDTH; // 9 bits per byte lane.
  localparam int DEPTH  = `QDR_MAX_LAT + `QDR_MAX_SKEW;
  localparam int WORDS  = 2 ** `QDR_ADDR_WIDTH;

  qdr_word_t mem  [WORDS];
  qdr_word_t pipe [DEPTH]; // pipe[0] holds the word read at the last edge.
  qdr_word_t wr_word;
  qdr_word_t q_word;

  // unwritten locations read as zero.
  initial begin
    for (int a = 0; a < WORDS; a++) mem[a] = '0;
    for (int k = 0; k < DEPTH; k++) pipe[k] = '0;
  end

  // ******************************
  // write port with byte lanes
  // ******************************
  always @(posedge clk0) begin
    wr_word = mem[qdr_out.sa];
    for (int b = 0; b < `QDR_BW_WIDTH; b++) begin
      if (!qdr_out.bw_n_rise[b]) begin
        wr_word[b*BYTE_W +: BYTE_W] = qdr_out.d_rise[b*BYTE_W +: BYTE_W];
      end
      if (!qdr_out.bw_n_fall[b]) begin
        wr_word[`QDR_DATA_WIDTH + b*BYTE_W +: BYTE_W] = qdr_out.d_fall[b*BYTE_W +: BYTE_W];
      end
    end
    if (!qdr_out.w_n) mem[qdr_out.sa] <= wr_word;
  end

  // ******************************
  // read pipeline
  // ******************************
  always @(posedge clk0) begin
    pipe[0] <= qdr_out.r_n ? '0 : mem[qdr_out.sa]; // idle cycles return zeros.
    for (int k = 1; k < DEPTH; k++) pipe[k] <= pipe[k-1];
  end

  // each bit arrives base_lat + its own skew edges after the read.
  always_comb begin
    for (int i = 0; i < NBITS; i++) begin
      q_word[i] = pipe[int'(base_lat) + int'(skew[i]) - 1][i];
    end
  end

  assign qdr_in.q_rise = q_word[`QDR_DATA_WIDTH-1:0];
  assign qdr_in.q_fall = q_word[NBITS-1:`QDR_DATA_WIDTH];

endmodule

// File: verification/qdrc_golden.txt
# L lat skews: base read latency, then one hex skew digit per bit, bit 35 first
# W addr data ben | R addr expected, all hex; data is fall half over rise half
L 3 000100203000010000300200001000000320
W 10 123456789 F
R 10 123456789
W 11 FFFFC0000 F
R 11 FFFFC0000
W 12 00003FFFF F
R 12 00003FFFF
W 13 0DEADBEEF F
R 13 0DEADBEEF
R 30 000000000
W 20 000000000 F
W 20 FFFFFFFFF 5
R 20 007FC01FF
W 21 FFFFFFFFF A
R 21 FF803FE00
W 21 000000000 2
R 21 FF8000000
W 22 123456789 F
W 22 FFFFFFFFF 1
R 22 1234567FF
R 10 123456789
R 11 FFFFC0000

// File: verification/tb_qdrc_top.sv
`timescale 1ns/10ps
`include "qdrc_config.svh"

module tb_qdrc_top import qdrc_pkg::*; ();

  localparam int NBITS      = 2 * `QDR_DATA_WIDTH;
  localparam int WAIT_LIMIT = 100; // cycles per handshake phase.
  localparam int CAL_LIMIT  = 500;

  logic                  clk0;
  logic                  arst_n;
  logic                  req;
  user_req_t             user_req;
  logic                  ack;
  qdr_word_t             rd_data;
  logic                  phy_rdy;
  logic                  cal_fail;
  qdr_pins_out_t         qdr_out;
  qdr_pins_in_t          qdr_in;
  lat_t                  base_lat;
  logic [NBITS-1:0][1:0] skew;
  user_req_t             ops [$]; // reads keep the expected word in wdata.
  int                    errors;
  int                    timeouts;

  qdrc_top dut0 (
    .clk0     (clk0),
    .arst_n   (arst_n),
    .req      (req),
    .user_req (user_req),
    .ack      (ack),
    .rd_data  (rd_data),
    .phy_rdy  (phy_rdy),
    .cal_fail (cal_fail),
    .qdr_out  (qdr_out),
    .qdr_in   (qdr_in)
  );

  qdr_sram_model sram0 (
    .clk0     (clk0),
    .base_lat (base_lat),
    .skew     (skew),
    .qdr_out  (qdr_out),
    .qdr_in   (qdr_in)
  );

  initial begin
    clk0 = 1'b0;
    forever #5 clk0 = ~clk0; // 10 ns period.
  end

  // ******************************
  // golden file
  // ******************************
  task automatic load_golden();
    int                 fd;
    int                 n;
    int                 lat;
    string              line;
    logic [4*NBITS-1:0] skew_raw;
    logic [31:0]        a;
    logic [31:0]        b;
    qdr_word_t          d;
    user_req_t          op;
    fd = $fopen("verification/qdrc_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open the golden file");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2 || line.getc(0) == "#") continue;
      op = '0;
      case (line.getc(0))
        "L": begin
          n = $sscanf(line, "L %d %h", lat, skew_raw);
          assert (lat >= 1 && lat + `QDR_MAX_SKEW - 1 <= `QDR_MAX_LAT) else begin
            $display("golden file gives a base latency out of range");
            errors++;
          end
          base_lat = lat_t'(lat);
          for (int i = 0; i < NBITS; i++) skew[i] = skew_raw[4*i +: 2]; // one digit per bit.
        end
        "W": begin
          n = $sscanf(line, "W %h %h %h", a, d, b);
          op.we    = 1'b1;
          op.addr  = qdr_addr_t'(a);
          op.wdata = d;
          op.ben   = qdr_ben_t'(b);
          ops.push_back(op);
        end
        "R": begin
          n = $sscanf(line, "R %h %h", a, d);
          op.addr  = qdr_addr_t'(a);
          op.wdata = d;
          ops.push_back(op);
        end
        default: begin
          $display("golden file holds a line that is not understood");
          errors++;
        end
      endcase
    end
    $fclose(fd);
  endtask

  // ******************************
  // handshake steps
  // ******************************
  task automatic raise_req(input user_req_t r);
    @(posedge clk0);
    req      <= 1'b1;
    user_req <= r;
  endtask

  task automatic wait_calibration();
    int cycles;
    cycles = 0;
    while (!phy_rdy && !cal_fail && cycles < CAL_LIMIT) begin
      @(negedge clk0);
      cycles++;
      assert (!ack) else begin
        $display("FAIL ack before phy_rdy: got %h, expected %h", ack, 1'b0);
        errors++;
      end
    end
    assert (!cal_fail) else begin
      $display("FAIL cal_fail: got %h, expected %h", cal_fail, 1'b0);
      errors++;
    end
    if (!phy_rdy && !cal_fail) begin
      $display("timeout: calibration did not finish");
      timeouts++;
    end
  endtask

  task automatic wait_ack_high(output int cycles);
    cycles = 0;
    do begin
      @(posedge clk0);
      cycles++;
      @(negedge clk0);
    end while (!ack && cycles < WAIT_LIMIT);
    if (!ack) begin
      $display("timeout: request was never acknowledged");
      timeouts++;
    end
  endtask

  task automatic release_req();
    int cycles;
    repeat (2) begin // ack must hold while req stays up.
      @(negedge clk0);
      assert (ack) else begin
        $display("FAIL ack while req high: got %h, expected %h", ack, 1'b1);
        errors++;
      end
    end
    @(posedge clk0);
    req    <= 1'b0;
    cycles = 0;
    do begin
      @(negedge clk0);
      cycles++;
    end while (ack && cycles < WAIT_LIMIT);
    if (ack) begin
      $display("timeout: ack stayed high after req fell");
      timeouts++;
    end
  endtask

  task automatic run_op(input int idx, input bit early);
    user_req_t op;
    user_req_t drv;
    int        cycles;
    op  = ops[idx];
    drv = op;
    if (!op.we) drv.wdata = '0;
    raise_req(drv);
    if (early) wait_calibration(); // request already waiting.
    if (timeouts == 0) wait_ack_high(cycles);
    if (timeouts != 0) return;
    if (op.we && !early) begin
      assert (cycles == 2) else begin
        $display("FAIL ack delay for write to %h: got %h, expected %h", op.addr, cycles, 2);
        errors++;
      end
    end
    if (!op.we) begin
      assert (rd_data == op.wdata) else begin
        $display("FAIL rd_data at %h: got %h, expected %h", op.addr, rd_data, op.wdata);
        errors++;
      end
    end
    release_req();
  endtask

  // ******************************
  // main sequence
  // ******************************
  initial begin
    arst_n   = 1'b0;
    req      = 1'b0;
    user_req = '0;
    base_lat = lat_t'(1);
    skew     = '0;
    errors   = 0;
    timeouts = 0;
    load_golden();
    @(posedge clk0);
    @(negedge clk0);
    assert (!ack && !phy_rdy && !cal_fail && qdr_out.w_n && qdr_out.r_n) else begin
      $display("FAIL {ack,phy_rdy,cal_fail,w_n,r_n} in reset: got %h, expected %h",
               {ack, phy_rdy, cal_fail, qdr_out.w_n, qdr_out.r_n}, 5'b00011);
      errors++;
    end
    @(posedge clk0);
    arst_n <= 1'b1;
    for (int i = 0; i < ops.size() && timeouts == 0; i++) run_op(i, i == 0);
    assert (!cal_fail) else begin
      $display("FAIL cal_fail: got %h, expected %h", cal_fail, 1'b0);
      errors++;
    end
    $display("errors: %0d failed checks, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
